// File: hw/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// data word width.
`define CPU_DATA_W 16

// program counter width.
`define CPU_PC_W 8

// instruction memory depth in words.
`define CPU_IMEM_DEPTH 256

// opcode field width.
`define CPU_OPC_W 8

// general registers X, Y, Z, R, R1, R2, R3.
`define CPU_NUM_REGS 7

`endif

// File: hw/cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_W-1:0] data_t;
    typedef logic [`CPU_PC_W-1:0]   pc_t;

    // sparse opcode numbering.
    typedef enum logic [`CPU_OPC_W-1:0] {
        OP_NOP    = 8'd4,
        OP_ADD    = 8'd5,
        OP_SUB    = 8'd9,
        OP_MVAC   = 8'd20,
        OP_MOVREG = 8'd21,
        OP_CLAC   = 8'd22,
        OP_JUMP   = 8'd24,
        OP_JUMPZ  = 8'd27,
        OP_JMNZ   = 8'd29,
        OP_INCAC  = 8'd31,
        OP_INCR   = 8'd32,
        OP_INCR3  = 8'd33,
        OP_SFTR   = 8'd34,
        OP_SFTL   = 8'd36,
        OP_ENDOP  = 8'd40
    } opcode_e;

    typedef enum logic [3:0] {
        REG_NONE = 4'd0,
        REG_X    = 4'd1,
        REG_Y    = 4'd2,
        REG_Z    = 4'd3,
        REG_R    = 4'd7,
        REG_R1   = 4'd8,
        REG_R2   = 4'd9,
        REG_R3   = 4'd10
    } reg_sel_e;

    typedef struct packed {
        opcode_e    opcode;
        logic [3:0] unused;
        reg_sel_e   sel;
    } instr_reg_t;

    typedef struct packed {
        opcode_e opcode;
        pc_t     target;
    } instr_jmp_t;

    // same word, register form or jump form.
    typedef union packed {
        instr_reg_t rf;
        instr_jmp_t jf;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_NONE,
        ALU_ADD,
        ALU_SUB,
        ALU_SHR,
        ALU_SHL,
        ALU_ZERO,
        ALU_INC,
        ALU_LOAD
    } alu_op_e;

    typedef enum logic [1:0] {
        PC_HOLD,
        PC_INC,
        PC_JUMP
    } pc_op_e;

    typedef enum logic [1:0] {
        ST_PREPARE  = 2'd0,
        ST_PROCESS  = 2'd1,
        ST_COMPLETE = 2'd3
    } status_e;

    typedef struct packed {
        logic     ir_load;
        pc_op_e   pc_op;
        reg_sel_e reg_rd;
        reg_sel_e reg_wr;
        reg_sel_e reg_inc;
        alu_op_e  ac_op;
    } ctrl_t;

    typedef struct packed {
        logic  en;
        pc_t   addr;
        data_t data;
    } load_t;

endpackage

// File: hw/cpu_control.sv
module cpu_control
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  status_e status,
    input  instr_u  ir,
    input  logic    zero,
    output ctrl_t   ctrl,
    output logic    finish
);

    typedef enum logic [4:0] {
        S_IDLE,
        S_FETCH1,
        S_FETCH2,
        S_FETCH3,
        S_NOP,
        S_ADD,
        S_SUB,
        S_CLAC,
        S_SFTR,
        S_SFTL,
        S_WRBACK,
        S_MVAC,
        S_MOVREG,
        S_JUMP,
        S_JUMPZ,
        S_JMNZ,
        S_INCAC,
        S_INCR,
        S_INCR3,
        S_DONE
    } state_e;

    state_e state_q;
    state_e state_d;
    state_e dec_state;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state_q <= S_IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    // opcode to first execute state.
    always_comb
    begin
        case (ir.rf.opcode)
            OP_ADD:    dec_state = S_ADD;
            OP_SUB:    dec_state = S_SUB;
            OP_MVAC:   dec_state = S_MVAC;
            OP_MOVREG: dec_state = S_MOVREG;
            OP_CLAC:   dec_state = S_CLAC;
            OP_JUMP:   dec_state = S_JUMP;
            OP_JUMPZ:  dec_state = S_JUMPZ;
            OP_JMNZ:   dec_state = S_JMNZ;
            OP_INCAC:  dec_state = S_INCAC;
            OP_INCR:   dec_state = S_INCR;
            OP_INCR3:  dec_state = S_INCR3;
            OP_SFTR:   dec_state = S_SFTR;
            OP_SFTL:   dec_state = S_SFTL;
            OP_ENDOP:  dec_state = S_DONE;
            default:   dec_state = S_NOP;
        endcase
    end

    always_comb
    begin
        state_d       = state_q;
        ctrl.ir_load  = 1'b0;
        ctrl.pc_op    = PC_HOLD;
        ctrl.reg_rd   = REG_NONE;
        ctrl.reg_wr   = REG_NONE;
        ctrl.reg_inc  = REG_NONE;
        ctrl.ac_op    = ALU_NONE;
        case (state_q)
            S_IDLE:
            begin
                if (status == ST_PROCESS)
                begin
                    state_d = S_FETCH1;
                end
            end
            S_FETCH1: state_d = S_FETCH2;
            S_FETCH2:
            begin
                ctrl.ir_load = 1'b1;
                state_d      = S_FETCH3;
            end
            S_FETCH3:
            begin
                ctrl.pc_op = PC_INC;
                state_d    = dec_state;
            end
            S_ADD, S_SUB:
            begin
                ctrl.reg_rd = ir.rf.sel;
                ctrl.ac_op  = (state_q == S_ADD) ? ALU_ADD : ALU_SUB;
                state_d     = S_WRBACK;
            end
            S_CLAC:
            begin
                ctrl.ac_op = ALU_ZERO;
                state_d    = S_WRBACK;
            end
            S_SFTR:
            begin
                ctrl.ac_op = ALU_SHR;
                state_d    = S_WRBACK;
            end
            S_SFTL:
            begin
                ctrl.ac_op = ALU_SHL;
                state_d    = S_WRBACK;
            end
            // acc_alu moves the pending result into AC here.
            S_WRBACK: state_d = S_FETCH1;
            S_MVAC:
            begin
                ctrl.reg_wr = ir.rf.sel;
                state_d     = S_FETCH1;
            end
            S_MOVREG:
            begin
                ctrl.reg_rd = ir.rf.sel;
                ctrl.ac_op  = ALU_LOAD;
                state_d     = S_FETCH1;
            end
            S_JUMP:
            begin
                ctrl.pc_op = PC_JUMP;
                state_d    = S_FETCH1;
            end
            S_JUMPZ:
            begin
                ctrl.pc_op = zero ? PC_JUMP : PC_HOLD;
                state_d    = S_FETCH1;
            end
            S_JMNZ:
            begin
                ctrl.pc_op = zero ? PC_HOLD : PC_JUMP;
                state_d    = S_FETCH1;
            end
            S_INCAC:
            begin
                ctrl.ac_op = ALU_INC;
                state_d    = S_FETCH1;
            end
            S_INCR:
            begin
                ctrl.reg_inc = REG_R;
                state_d      = S_FETCH1;
            end
            S_INCR3:
            begin
                ctrl.reg_inc = REG_R3;
                state_d      = S_FETCH1;
            end
            S_DONE:  state_d = S_DONE;
            default: state_d = S_FETCH1;
        endcase
    end

    // held until reset.
    assign finish = (state_q == S_DONE);

endmodule

// File: hw/instr_fetch.sv
`include "cpu_consts.svh"

module instr_fetch
    import cpu_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  ctrl_t  ctrl,
    input  load_t  load,
    output instr_u ir
);

    data_t imem [`CPU_IMEM_DEPTH];
    data_t mem_q;
    pc_t   pc;

    // load port write, synchronous read at the pc.
    always_ff @(posedge clk)
    begin
        if (load.en)
        begin
            imem[load.addr] <= load.data;
        end
        mem_q <= imem[pc];
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc <= '0;
            ir <= '0;
        end
        else
        begin
            case (ctrl.pc_op)
                PC_INC:  pc <= pc + 1'b1;
                PC_JUMP: pc <= ir.jf.target;
                default: pc <= pc;
            endcase
            if (ctrl.ir_load)
            begin
                ir <= mem_q;
            end
        end
    end

endmodule

// File: hw/reg_file.sv
`include "cpu_consts.svh"

module reg_file
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  ctrl_t ctrl,
    input  data_t ac,
    output data_t rd_data
);

    // select code of each slot.
    localparam reg_sel_e REG_IDS [`CPU_NUM_REGS] =
        '{REG_X, REG_Y, REG_Z, REG_R, REG_R1, REG_R2, REG_R3};

    data_t regs [`CPU_NUM_REGS];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < `CPU_NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else
        begin
            for (int i = 0; i < `CPU_NUM_REGS; i++)
            begin
                if (ctrl.reg_wr == REG_IDS[i])
                begin
                    regs[i] <= ac;
                end
                else if (ctrl.reg_inc == REG_IDS[i])
                begin
                    regs[i] <= regs[i] + 1'b1;
                end
            end
        end
    end

    // none of the slots match REG_NONE, so it reads 0.
    always_comb
    begin
        rd_data = '0;
        for (int i = 0; i < `CPU_NUM_REGS; i++)
        begin
            if (ctrl.reg_rd == REG_IDS[i])
            begin
                rd_data = regs[i];
            end
        end
    end

endmodule

// File: hw/acc_alu.sv
module acc_alu
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  ctrl_t ctrl,
    input  data_t rd_data,
    output data_t ac,
    output logic  zero
);

    data_t alu_next;
    data_t alu_res;
    logic  operate;
    logic  res_pend;

    assign operate = ctrl.ac_op inside {ALU_ADD, ALU_SUB, ALU_SHR, ALU_SHL, ALU_ZERO};

    always_comb
    begin
        case (ctrl.ac_op)
            ALU_ADD: alu_next = ac + rd_data;
            ALU_SUB: alu_next = ac - rd_data;
            ALU_SHR: alu_next = ac >> 1;
            ALU_SHL: alu_next = ac << 1;
            default: alu_next = '0;
        endcase
    end

    // operate step result.
    always_ff @(posedge clk)
    begin
        if (operate)
        begin
            alu_res <= alu_next;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ac       <= '0;
            res_pend <= 1'b0;
        end
        else
        begin
            res_pend <= operate;
            if (res_pend)
            begin
                ac <= alu_res;
            end
            else if (ctrl.ac_op == ALU_LOAD)
            begin
                ac <= rd_data;
            end
            else if (ctrl.ac_op == ALU_INC)
            begin
                ac <= ac + 1'b1;
            end
        end
    end

    assign zero = (ac == '0);

endmodule

// File: hw/cpu_top.sv
module cpu_top
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  status_e status,
    input  load_t   load,
    output logic    finish,
    output data_t   ac
);

    ctrl_t  ctrl;
    instr_u ir;
    logic   zero;
    data_t  rd_data;

    cpu_control u_control (
        .clk    (clk),
        .arst_n (arst_n),
        .status (status),
        .ir     (ir),
        .zero   (zero),
        .ctrl   (ctrl),
        .finish (finish)
    );

    instr_fetch u_fetch (
        .clk    (clk),
        .arst_n (arst_n),
        .ctrl   (ctrl),
        .load   (load),
        .ir     (ir)
    );

    reg_file u_regs (
        .clk     (clk),
        .arst_n  (arst_n),
        .ctrl    (ctrl),
        .ac      (ac),
        .rd_data (rd_data)
    );

    acc_alu u_alu (
        .clk     (clk),
        .arst_n  (arst_n),
        .ctrl    (ctrl),
        .rd_data (rd_data),
        .ac      (ac),
        .zero    (zero)
    );

endmodule

// File: tb/cpu_checker.sv
module cpu_checker
    import cpu_pkg::*;
(
    input logic  clk,
    input logic  arst_n,
    input ctrl_t ctrl,
    input logic  finish
);

    // read by the testbench summary.
    int fail_count = 0;

    finish_held: assert property (
        @(posedge clk) disable iff (!arst_n) finish |=> finish
    )
    else
    begin
        $error("finish dropped without a reset");
        fail_count++;
    end

    // one register port active at a time.
    wr_inc_excl: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(ctrl.reg_wr != REG_NONE && ctrl.reg_inc != REG_NONE)
    )
    else
    begin
        $error("reg_wr and reg_inc both select a register");
        fail_count++;
    end

    load_jump_excl: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(ctrl.ir_load && ctrl.pc_op == PC_JUMP)
    )
    else
    begin
        $error("ir_load coincides with a pc jump");
        fail_count++;
    end

endmodule

bind cpu_control cpu_checker u_checker (
    .clk    (clk),
    .arst_n (arst_n),
    .ctrl   (ctrl),
    .finish (finish)
);

// File: tb/cpu_tb.sv
module cpu_tb
    import cpu_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 2000;

    logic    clk = 1'b0;
    logic    arst_n;
    status_e status;
    load_t   load;
    logic    finish;
    data_t   ac;

    data_t prog[$];
    int    test_errors;
    int    tests_run = 0;
    int    tests_failed = 0;

    always #2 clk = ~clk;

    cpu_top u_dut (
        .clk    (clk),
        .arst_n (arst_n),
        .status (status),
        .load   (load),
        .finish (finish),
        .ac     (ac)
    );

    function automatic void emit_op(opcode_e op);
        prog.push_back({op, 8'h00});
    endfunction

    function automatic void emit_reg(opcode_e op, reg_sel_e sel);
        prog.push_back({op, 4'h0, sel});
    endfunction

    function automatic void emit_jmp(opcode_e op, pc_t target);
        prog.push_back({op, target});
    endfunction

    task automatic check_data(string name, data_t got, data_t exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_finish(string name, logic got, logic exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic report_test(string name);
        tests_run++;
        if (test_errors == 0)
        begin
            $display("%s: ok", name);
        end
        else
        begin
            $display("%s: %0d errors", name, test_errors);
            tests_failed++;
        end
    endtask

    task automatic reset_dut();
        @(posedge clk);
        arst_n <= 1'b0;
        status <= ST_PREPARE;
        load   <= '0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    // one load strobe per word while status is prepare.
    task automatic load_program();
        foreach (prog[i])
        begin
            @(posedge clk);
            load <= '{en: 1'b1, addr: pc_t'(i), data: prog[i]};
        end
        @(posedge clk);
        load <= '0;
    endtask

    task automatic run_program();
        int   cycles;
        logic done;
        reset_dut();
        load_program();
        @(posedge clk);
        status <= ST_PROCESS;
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < TIMEOUT_CYCLES)
        begin
            @(negedge clk);
            done = finish;
            cycles++;
        end
        if (!done)
        begin
            $display("finish did not rise within %0d cycles", TIMEOUT_CYCLES);
            test_errors++;
        end
    endtask

    task automatic test_idle();
        test_errors = 0;
        reset_dut();
        repeat (20)
        begin
            @(negedge clk);
            check_finish("finish", finish, 1'b0);
            check_data("ac", ac, '0);
        end
        report_test("idle after reset");
    endtask

    task automatic test_arith(bit with_sub);
        int    n;
        int    m;
        data_t exp;
        test_errors = 0;
        n   = 1 + int'($urandom % 8);
        m   = 1 + int'($urandom % 8);
        // ac = 2n+m after ADD X, Y takes that value, SUB Y clears it.
        exp = with_sub ? data_t'(0) : data_t'(2 * n + m);
        prog.delete();
        emit_op(OP_CLAC);
        emit_op(OP_NOP);
        repeat (n) emit_op(OP_INCAC);
        emit_reg(OP_MVAC, REG_X);
        repeat (m) emit_op(OP_INCAC);
        emit_reg(OP_ADD, REG_X);
        emit_reg(OP_MVAC, REG_Y);
        if (with_sub)
            emit_reg(OP_SUB, REG_Y);
        emit_op(OP_ENDOP);
        run_program();
        check_data("ac", ac, exp);
        check_finish("finish", finish, 1'b1);
        report_test($sformatf("arithmetic n=%0d m=%0d sub=%0d", n, m, with_sub));
    endtask

    task automatic test_moves(reg_sel_e sel);
        int    v;
        data_t exp;
        test_errors = 0;
        v   = 1 + int'($urandom % 12);
        exp = (sel == REG_R) ? data_t'(v + 2) : data_t'(v + 1);
        prog.delete();
        emit_op(OP_CLAC);
        repeat (v) emit_op(OP_INCAC);
        emit_reg(OP_MVAC, REG_R);
        emit_reg(OP_MVAC, REG_R3);
        emit_op(OP_INCR);
        emit_op(OP_INCR);
        emit_op(OP_INCR3);
        emit_reg(OP_MOVREG, sel);
        emit_op(OP_ENDOP);
        run_program();
        check_data("ac", ac, exp);
        check_finish("finish", finish, 1'b1);
        report_test($sformatf("register moves v=%0d read %s", v, sel.name()));
    endtask

    task automatic test_shift(int a, int lefts, int rights);
        data_t exp;
        test_errors = 0;
        // logical shifts, zero fill at both ends.
        exp = data_t'(a);
        exp = exp << lefts;
        exp = exp >> rights;
        prog.delete();
        emit_op(OP_CLAC);
        repeat (a) emit_op(OP_INCAC);
        repeat (lefts) emit_op(OP_SFTL);
        repeat (rights) emit_op(OP_SFTR);
        emit_op(OP_ENDOP);
        run_program();
        check_data("ac", ac, exp);
        check_finish("finish", finish, 1'b1);
        report_test($sformatf("shift %0d left %0d right %0d", a, lefts, rights));
    endtask

    task automatic test_countdown(int k);
        pc_t loop_pc;
        test_errors = 0;
        prog.delete();
        emit_op(OP_CLAC);
        emit_op(OP_INCAC);
        emit_reg(OP_MVAC, REG_X);
        repeat (k - 1) emit_op(OP_INCAC);
        loop_pc = pc_t'(prog.size());
        emit_op(OP_INCR3);
        emit_reg(OP_SUB, REG_X);
        emit_jmp(OP_JMNZ, loop_pc);
        emit_op(OP_ENDOP);
        run_program();
        check_data("ac", ac, '0);
        check_finish("finish", finish, 1'b1);
        report_test($sformatf("countdown k=%0d", k));
    endtask

    // jumpz skips one INCAC when ac is 0, JUMP always skips two.
    task automatic test_jumpz(int j);
        data_t exp;
        test_errors = 0;
        exp = (j == 0) ? data_t'(0) : data_t'(j + 1);
        prog.delete();
        emit_op(OP_CLAC);
        repeat (j) emit_op(OP_INCAC);
        emit_jmp(OP_JUMPZ, pc_t'(prog.size() + 2));
        emit_op(OP_INCAC);
        emit_jmp(OP_JUMP, pc_t'(prog.size() + 3));
        emit_op(OP_INCAC);
        emit_op(OP_INCAC);
        emit_op(OP_ENDOP);
        run_program();
        check_data("ac", ac, exp);
        check_finish("finish", finish, 1'b1);
        report_test($sformatf("jumpz j=%0d", j));
    endtask

    initial
    begin
        int assert_fails;
        void'($urandom(32'h6abd_1f0f));
        arst_n = 1'b0;
        status = ST_PREPARE;
        load   = '0;
        test_idle();
        test_arith(1'b1);
        test_arith(1'b0);
        test_moves(REG_R);
        test_moves(REG_R3);
        test_shift(5, 1, 0);
        test_shift(5, 0, 1);
        test_shift(1 + int'($urandom % 15), 1, 1);
        test_shift(3, 15, 15);
        test_countdown(2 + int'($urandom % 6));
        test_jumpz(0);
        test_jumpz(1 + int'($urandom % 9));
        assert_fails = u_dut.u_control.u_checker.fail_count;
        $display("summary: %0d run, %0d with errors, %0d assertion failures",
                 tests_run, tests_failed, assert_fails);
        if (tests_failed == 0 && assert_fails == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+hw
hw/cpu_pkg.sv
hw/cpu_control.sv
hw/instr_fetch.sv
hw/reg_file.sv
hw/acc_alu.sv
hw/cpu_top.sv
tb/cpu_checker.sv
tb/cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
